//--- Makefile
# Verilator flow for the line-drawing subsystem

VERILATOR ?= verilator
TOP       ?= tb_bla_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= Done: no errors

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass line appears in the simulation output
sim: $(BUILD_DIR)/V$(TOP)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
rtl/bla_pkg.sv
rtl/bla_axil_regs.sv
rtl/bresenham_controller.sv
rtl/bresenham_line.sv
rtl/bla_top.sv
tests/bla_checker.sv
tests/tb_bla_top.sv

//--- rtl/bla_axil_regs.sv
`timescale 1ns/1ps

module bla_axil_regs #(
	parameter int COORD_BITS = 8
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [bla_pkg::axil_addr_bits-1:0]  s_awaddr,
	input  logic                                s_awvalid,
	output logic                                s_awready,
	input  logic [31:0]                         s_wdata,
	input  logic [3:0]                          s_wstrb,
	input  logic                                s_wvalid,
	output logic                                s_wready,
	output logic [1:0]                          s_bresp,
	output logic                                s_bvalid,
	input  logic                                s_bready,
	input  logic [bla_pkg::axil_addr_bits-1:0]  s_araddr,
	input  logic                                s_arvalid,
	output logic                                s_arready,
	output logic [31:0]                         s_rdata,
	output logic [1:0]                          s_rresp,
	output logic                                s_rvalid,
	input  logic                                s_rready,
	output logic                                start,
	output bla_pkg::shape_t                     shape,
	output logic [6*COORD_BITS-1:0]             coordinates,
	input  logic                                bla_done
);
	import bla_pkg::*;

	// y field starts at bit 8 of a vertex word
	localparam int y_lsb = 8;
	localparam logic [31:0] field_ones = (32'd1 << COORD_BITS) - 32'd1;
	localparam logic [31:0] vert_mask = field_ones | (field_ones << y_lsb);

	logic        wr_ready;
	logic        wr_en;
	logic        rd_en;
	logic [31:0] wmask;
	logic [31:0] vert_q [3];
	logic [31:0] rd_word;
	shape_t      shape_q;
	logic        busy;
	logic        done;
	logic        ctrl_wr;
	logic        start_wr;
	logic        done_clr;

	assign s_awready = wr_ready;
	assign s_wready  = wr_ready;
	assign s_bresp   = 2'b00;
	assign s_rresp   = 2'b00;

	assign wr_en    = wr_ready & s_awvalid & s_wvalid;
	assign rd_en    = s_arready & s_arvalid;
	assign ctrl_wr  = wr_en && (s_awaddr == addr_ctrl) && s_wstrb[0];
	assign start_wr = ctrl_wr && s_wdata[ctrl_start_bit] && !busy;
	assign done_clr = wr_en && (s_awaddr == addr_status) && s_wstrb[0]
		&& s_wdata[status_done_bit];

	always_comb
	begin
		for (int i = 0; i < 4; i++)
			wmask[8*i +: 8] = {8{s_wstrb[i]}};
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ready  <= 1'b0;
			s_bvalid  <= 1'b0;
			s_arready <= 1'b0;
			s_rvalid  <= 1'b0;
			start     <= 1'b0;
			busy      <= 1'b0;
			done      <= 1'b0;
			shape_q   <= shape_line;
			for (int i = 0; i < 3; i++)
				vert_q[i] <= '0;
		end
		else
		begin
			wr_ready <= s_awvalid && s_wvalid && !wr_ready && !s_bvalid;
			if (wr_en)
				s_bvalid <= 1'b1;
			else if (s_bready)
				s_bvalid <= 1'b0;

			s_arready <= s_arvalid && !s_arready && !s_rvalid;
			if (rd_en)
				s_rvalid <= 1'b1;
			else if (s_rready)
				s_rvalid <= 1'b0;

			start <= start_wr;
			if (start_wr)
				busy <= 1'b1;
			else if (bla_done)
				busy <= 1'b0;
			// A new drawing clears the old done
			if (bla_done)
				done <= 1'b1;
			else if (start_wr || done_clr)
				done <= 1'b0;

			// Configuration is frozen while drawing
			if (ctrl_wr && !busy)
				shape_q <= shape_t'(s_wdata[ctrl_shape_bit]);
			for (int i = 0; i < 3; i++)
			begin
				if (wr_en && !busy && (s_awaddr == addr_vert0 + 5'(4 * i)))
					vert_q[i] <= ((vert_q[i] & ~wmask) | (s_wdata & wmask)) & vert_mask;
			end
		end
	end

	always_comb
	begin
		rd_word = '0;
		case (s_araddr)
			addr_ctrl:   rd_word[ctrl_shape_bit] = shape_q;
			addr_vert0:  rd_word = vert_q[0];
			addr_vert1:  rd_word = vert_q[1];
			addr_vert2:  rd_word = vert_q[2];
			addr_status:
			begin
				rd_word[status_busy_bit] = busy;
				rd_word[status_done_bit] = done;
			end
			default:     rd_word = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rd_en)
			s_rdata <= rd_word;
	end

	assign shape = shape_q;

	always_comb
	begin
		for (int i = 0; i < 3; i++)
		begin
			coordinates[2*i*COORD_BITS +: COORD_BITS]     = vert_q[i][COORD_BITS-1:0];
			coordinates[(2*i+1)*COORD_BITS +: COORD_BITS] = vert_q[i][y_lsb +: COORD_BITS];
		end
	end

	bvalid_after_write: assert property (@(posedge clk) disable iff (reset)
		$rose(s_bvalid) |-> $past(wr_en));

endmodule

//--- rtl/bla_pkg.sv
package bla_pkg;

	// One edge or three
	typedef enum logic {
		shape_line     = 1'b0,
		shape_triangle = 1'b1
	} shape_t;

	localparam int axil_addr_bits = 5;

	// Register byte offsets
	localparam logic [axil_addr_bits-1:0] addr_ctrl   = 5'h00;
	localparam logic [axil_addr_bits-1:0] addr_vert0  = 5'h04;
	localparam logic [axil_addr_bits-1:0] addr_vert1  = 5'h08;
	localparam logic [axil_addr_bits-1:0] addr_vert2  = 5'h0C;
	localparam logic [axil_addr_bits-1:0] addr_status = 5'h10;

	// Control register
	localparam int ctrl_start_bit = 0;
	localparam int ctrl_shape_bit = 1;

	// Status register with a write-one-to-clear done bit
	localparam int status_busy_bit = 0;
	localparam int status_done_bit = 1;

endpackage

//--- rtl/bla_top.sv
`timescale 1ns/1ps

module bla_top #(
	parameter int COORD_BITS = 8
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [bla_pkg::axil_addr_bits-1:0]  s_awaddr,
	input  logic                                s_awvalid,
	output logic                                s_awready,
	input  logic [31:0]                         s_wdata,
	input  logic [3:0]                          s_wstrb,
	input  logic                                s_wvalid,
	output logic                                s_wready,
	output logic [1:0]                          s_bresp,
	output logic                                s_bvalid,
	input  logic                                s_bready,
	input  logic [bla_pkg::axil_addr_bits-1:0]  s_araddr,
	input  logic                                s_arvalid,
	output logic                                s_arready,
	output logic [31:0]                         s_rdata,
	output logic [1:0]                          s_rresp,
	output logic                                s_rvalid,
	input  logic                                s_rready,
	output logic                                pixel_valid,
	output logic [COORD_BITS-1:0]               pixel_x,
	output logic [COORD_BITS-1:0]               pixel_y,
	input  logic                                pixel_ready
);
	import bla_pkg::*;

	logic                    start;
	shape_t                  shape;
	logic [6*COORD_BITS-1:0] coordinates;
	logic                    bla_done;
	logic                    draw_en;
	logic                    draw_done;
	logic [COORD_BITS-1:0]   x0, y0, x1, y1;

	bla_axil_regs #(.COORD_BITS(COORD_BITS)) regs0 (
		.clk(clk), .reset(reset),
		.s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
		.s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wvalid(s_wvalid), .s_wready(s_wready),
		.s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
		.s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
		.s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
		.start(start), .shape(shape), .coordinates(coordinates), .bla_done(bla_done)
	);

	bresenham_controller #(.COORD_BITS(COORD_BITS)) ctrl0 (
		.clk(clk), .reset(reset), .start(start), .shape(shape),
		.coordinates(coordinates), .draw_en(draw_en),
		.x0(x0), .y0(y0), .x1(x1), .y1(y1),
		.draw_done(draw_done), .bla_done(bla_done)
	);

	bresenham_line #(.COORD_BITS(COORD_BITS)) line0 (
		.clk(clk), .reset(reset), .draw_en(draw_en),
		.x0(x0), .y0(y0), .x1(x1), .y1(y1), .draw_done(draw_done),
		.pixel_valid(pixel_valid), .pixel_x(pixel_x), .pixel_y(pixel_y),
		.pixel_ready(pixel_ready)
	);

endmodule

//--- rtl/bresenham_controller.sv
`timescale 1ns/1ps

module bresenham_controller #(
	parameter int COORD_BITS = 8
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     start,
	input  bla_pkg::shape_t          shape,
	input  logic [6*COORD_BITS-1:0]  coordinates,
	output logic                     draw_en,
	output logic [COORD_BITS-1:0]    x0,
	output logic [COORD_BITS-1:0]    y0,
	output logic [COORD_BITS-1:0]    x1,
	output logic [COORD_BITS-1:0]    y1,
	input  logic                     draw_done,
	output logic                     bla_done
);
	import bla_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_draw,
		st_draw_wait,
		st_done
	} state_t;

	state_t state_q, state_d;
	logic [1:0] edge_q, edge_d;
	logic [1:0] src_idx, dst_idx;
	logic load;
	logic last_edge;
	logic [COORD_BITS-1:0] vx [3];
	logic [COORD_BITS-1:0] vy [3];

	always_comb
	begin
		for (int i = 0; i < 3; i++)
		begin
			vx[i] = coordinates[2*i*COORD_BITS +: COORD_BITS];
			vy[i] = coordinates[(2*i+1)*COORD_BITS +: COORD_BITS];
		end
	end

	assign last_edge = (shape == shape_line) || (edge_q == 2'd2);

	always_comb
	begin
		state_d = state_q;
		edge_d  = edge_q;
		load    = 1'b0;
		case (state_q)
			st_idle:
				if (start)
				begin
					state_d = st_draw;
					edge_d  = 2'd0;
					load    = 1'b1;
				end
			st_draw:
				state_d = st_draw_wait;
			st_draw_wait:
				if (draw_done)
				begin
					if (last_edge)
						state_d = st_done;
					else
					begin
						state_d = st_draw;
						edge_d  = edge_q + 2'd1;
						load    = 1'b1;
					end
				end
			default:
				state_d = st_idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state_q <= st_idle;
			edge_q  <= 2'd0;
		end
		else
		begin
			state_q <= state_d;
			edge_q  <= edge_d;
		end
	end

	// Edge order v0-v1, v0-v2, v1-v2
	assign src_idx = (edge_d == 2'd2) ? 2'd1 : 2'd0;
	assign dst_idx = (edge_d == 2'd0) ? 2'd1 : 2'd2;

	// Endpoints keep their last value between edges
	always_ff @(posedge clk)
	begin
		if (load)
		begin
			x0 <= vx[src_idx];
			y0 <= vy[src_idx];
			x1 <= vx[dst_idx];
			y1 <= vy[dst_idx];
		end
	end

	assign draw_en  = (state_q == st_draw);
	assign bla_done = (state_q == st_done);

	done_in_wait: assert property (@(posedge clk) disable iff (reset)
		draw_done |-> state_q == st_draw_wait);

	draw_en_single: assert property (@(posedge clk) disable iff (reset)
		draw_en |=> !draw_en);

endmodule

//--- rtl/bresenham_line.sv
`timescale 1ns/1ps

module bresenham_line #(
	parameter int COORD_BITS = 8
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   draw_en,
	input  logic [COORD_BITS-1:0]  x0,
	input  logic [COORD_BITS-1:0]  y0,
	input  logic [COORD_BITS-1:0]  x1,
	input  logic [COORD_BITS-1:0]  y1,
	output logic                   draw_done,
	output logic                   pixel_valid,
	output logic [COORD_BITS-1:0]  pixel_x,
	output logic [COORD_BITS-1:0]  pixel_y,
	input  logic                   pixel_ready
);
	// Room for twice the error plus sign
	localparam int err_bits = COORD_BITS + 3;

	logic [COORD_BITS-1:0] end_x, end_y;
	logic [COORD_BITS-1:0] dx, dy;
	logic [COORD_BITS-1:0] dx_in, dy_in;
	logic x_neg, y_neg;
	logic signed [err_bits-1:0] err, err_next, e2;
	logic signed [err_bits-1:0] dx_s, dy_s;
	logic signed [err_bits-1:0] err_init;
	logic step_x, step_y;
	logic accept, at_end;

	assign accept = pixel_valid & pixel_ready;
	assign at_end = (pixel_x == end_x) && (pixel_y == end_y);

	assign dx_in = (x1 < x0) ? x0 - x1 : x1 - x0;
	assign dy_in = (y1 < y0) ? y0 - y1 : y1 - y0;
	assign err_init = {{(err_bits-COORD_BITS){1'b0}}, dx_in}
		- {{(err_bits-COORD_BITS){1'b0}}, dy_in};

	assign dx_s = {{(err_bits-COORD_BITS){1'b0}}, dx};
	assign dy_s = {{(err_bits-COORD_BITS){1'b0}}, dy};

	// Step decision for the current pixel
	always_comb
	begin
		e2 = err <<< 1;
		step_x = (e2 >= -dy_s);
		step_y = (e2 <= dx_s);
		err_next = err;
		if (step_x)
			err_next = err_next - dy_s;
		if (step_y)
			err_next = err_next + dx_s;
	end

	always_ff @(posedge clk)
	begin
		if (draw_en)
		begin
			pixel_x <= x0;
			pixel_y <= y0;
			end_x   <= x1;
			end_y   <= y1;
			dx      <= dx_in;
			dy      <= dy_in;
			x_neg   <= (x1 < x0);
			y_neg   <= (y1 < y0);
			err     <= err_init;
		end
		else if (accept && !at_end)
		begin
			if (step_x)
				pixel_x <= x_neg ? pixel_x - 1'b1 : pixel_x + 1'b1;
			if (step_y)
				pixel_y <= y_neg ? pixel_y - 1'b1 : pixel_y + 1'b1;
			err <= err_next;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pixel_valid <= 1'b0;
			draw_done   <= 1'b0;
		end
		else
		begin
			// Pulse once the endpoint is taken
			draw_done <= accept && at_end;
			if (draw_en)
				pixel_valid <= 1'b1;
			else if (accept && at_end)
				pixel_valid <= 1'b0;
		end
	end

	pixel_hold: assert property (@(posedge clk) disable iff (reset)
		(pixel_valid && !pixel_ready) |=>
			(pixel_valid && $stable(pixel_x) && $stable(pixel_y)));

endmodule

//--- tests/bla_checker.sv
`timescale 1ns/1ps

module bla_checker #(
	parameter int COORD_BITS = 8
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [4:0]             awaddr,
	input  logic                   awvalid,
	input  logic                   awready,
	input  logic [31:0]            wdata,
	input  logic [3:0]             wstrb,
	input  logic                   wvalid,
	input  logic                   wready,
	input  logic [1:0]             bresp,
	input  logic                   bvalid,
	input  logic                   bready,
	input  logic [4:0]             araddr,
	input  logic                   arvalid,
	input  logic                   arready,
	input  logic [31:0]            rdata,
	input  logic [1:0]             rresp,
	input  logic                   rvalid,
	input  logic                   rready,
	input  logic                   pixel_valid,
	input  logic                   pixel_ready,
	input  logic [COORD_BITS-1:0]  pixel_x,
	input  logic [COORD_BITS-1:0]  pixel_y,
	input  logic                   end_of_test,
	output logic                   reported,
	output int                     error_count,
	output int                     pixel_count,
	output int                     read_count
);
	localparam logic [4:0] reg_ctrl   = 5'h00;
	localparam logic [4:0] reg_vert0  = 5'h04;
	localparam logic [4:0] reg_vert1  = 5'h08;
	localparam logic [4:0] reg_vert2  = 5'h0C;
	localparam logic [4:0] reg_status = 5'h10;
	localparam logic [31:0] field_ones = (32'd1 << COORD_BITS) - 32'd1;
	// x in the low bits, y from bit 8
	localparam logic [31:0] vert_mask = field_ones | (field_ones << 8);

	logic [31:0] vert_m [3];
	logic        shape_m;
	logic        drawing;
	// 0 clear, 1 set, 2 unknown until a status read shows it
	int          done_state;
	int          exp_x [$];
	int          exp_y [$];
	logic [4:0]  rd_addr;
	logic [31:0] rd_exp;
	logic [31:0] rd_care;

	function automatic int vx(input int i);
		return int'(vert_m[i][COORD_BITS-1:0]);
	endfunction

	function automatic int vy(input int i);
		return int'(vert_m[i][8 +: COORD_BITS]);
	endfunction

	// Reference Bresenham with both endpoints included
	function automatic void push_edge(input int xa, input int ya, input int xb, input int yb);
		int dx;
		int dy;
		int sx;
		int sy;
		int err;
		int e2;
		int x;
		int y;
		int n;
		dx = (xb > xa) ? xb - xa : xa - xb;
		dy = (yb > ya) ? yb - ya : ya - yb;
		sx = (xb < xa) ? -1 : 1;
		sy = (yb < ya) ? -1 : 1;
		err = dx - dy;
		x = xa;
		y = ya;
		n = 0;
		exp_x.push_back(x);
		exp_y.push_back(y);
		while ((x != xb || y != yb) && n < 1024)
		begin
			e2 = 2 * err;
			if (e2 >= -dy)
			begin
				err = err - dy;
				x = x + sx;
			end
			if (e2 <= dx)
			begin
				err = err + dx;
				y = y + sy;
			end
			exp_x.push_back(x);
			exp_y.push_back(y);
			n++;
		end
	endfunction

	function automatic void queue_shape();
		push_edge(vx(0), vy(0), vx(1), vy(1));
		if (shape_m)
		begin
			push_edge(vx(0), vy(0), vx(2), vy(2));
			push_edge(vx(1), vy(1), vx(2), vy(2));
		end
	endfunction

	function automatic void expect_read(input logic [4:0] addr);
		rd_addr = addr;
		rd_exp  = '0;
		rd_care = '1;
		case (addr)
			reg_ctrl:
				rd_exp[1] = shape_m;
			reg_vert0, reg_vert1, reg_vert2:
				rd_exp = vert_m[addr[3:2] - 2'd1];
			reg_status:
			begin
				rd_exp[0] = drawing;
				rd_exp[1] = (done_state == 1);
				// Busy may linger a few cycles after the last pixel
				if (done_state == 2)
					rd_care[1:0] = 2'b00;
			end
			default:
				rd_exp = '0;
		endcase
	endfunction

	function automatic void check_read();
		read_count++;
		if ((rdata & rd_care) != (rd_exp & rd_care))
		begin
			error_count++;
			$display("[ERROR] s_rdata at %h expected %h actual %h", rd_addr, rd_exp, rdata);
		end
		if (rresp != 2'b00)
		begin
			error_count++;
			$display("[ERROR] s_rresp expected %h actual %h", 2'b00, rresp);
		end
		if (rd_addr == reg_status && done_state == 2 && rdata[1])
			done_state = 1;
	endfunction

	function automatic void check_pixel();
		pixel_count++;
		if (exp_x.size() == 0)
		begin
			error_count++;
			$display("Extra pixel (%0d, %0d) accepted while none was expected", pixel_x, pixel_y);
			return;
		end
		if (int'(pixel_x) != exp_x[0])
		begin
			error_count++;
			$display("[ERROR] pixel_x expected %h actual %h", exp_x[0], pixel_x);
		end
		if (int'(pixel_y) != exp_y[0])
		begin
			error_count++;
			$display("[ERROR] pixel_y expected %h actual %h", exp_y[0], pixel_y);
		end
		void'(exp_x.pop_front());
		void'(exp_y.pop_front());
		if (exp_x.size() == 0 && drawing)
		begin
			drawing = 1'b0;
			done_state = 2;
		end
	endfunction

	function automatic void apply_write();
		logic [31:0] merged;
		int idx;
		case (awaddr)
			reg_ctrl:
				if (wstrb[0] && !drawing)
				begin
					shape_m = wdata[1];
					if (wdata[0])
					begin
						drawing = 1'b1;
						done_state = 0;
						queue_shape();
					end
				end
			reg_vert0, reg_vert1, reg_vert2:
				if (!drawing)
				begin
					idx = int'(awaddr[3:2]) - 1;
					merged = vert_m[idx];
					for (int b = 0; b < 4; b++)
						if (wstrb[b])
							merged[8*b +: 8] = wdata[8*b +: 8];
					vert_m[idx] = merged & vert_mask;
				end
			reg_status:
				if (wstrb[0] && wdata[1] && done_state == 1)
					done_state = 0;
			default: ;
		endcase
	endfunction

	always @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 3; i++)
				vert_m[i] = '0;
			shape_m = 1'b0;
			drawing = 1'b0;
			done_state = 0;
			exp_x.delete();
			exp_y.delete();
			reported = 1'b0;
			error_count = 0;
			pixel_count = 0;
			read_count = 0;
		end
		else
		begin
			// Read data always trails its address by a cycle
			if (rvalid && rready)
				check_read();
			if (arvalid && arready)
				expect_read(araddr);
			if (pixel_valid && pixel_ready)
				check_pixel();
			// Address and data ready rise together
			if (awready != wready)
			begin
				error_count++;
				$display("[ERROR] s_wready expected %h actual %h", awready, wready);
			end
			if (bvalid && bready && bresp != 2'b00)
			begin
				error_count++;
				$display("[ERROR] s_bresp expected %h actual %h", 2'b00, bresp);
			end
			if (awvalid && wvalid && awready && wready)
				apply_write();
			if (end_of_test && !reported)
			begin
				if (exp_x.size() != 0)
				begin
					error_count++;
					$display("%0d expected pixels were never output", exp_x.size());
				end
				reported = 1'b1;
			end
		end
	end

endmodule

//--- tests/tb_bla_top.sv
`timescale 1ns/1ps

module tb_bla_top;
	localparam int coord_bits = 8;
	localparam int timeout_cycles = 100;
	localparam int poll_limit = 1000;
	localparam logic [4:0] reg_ctrl   = 5'h00;
	localparam logic [4:0] reg_vert0  = 5'h04;
	localparam logic [4:0] reg_status = 5'h10;

	logic                   clk;
	logic                   reset;
	logic [4:0]             s_awaddr;
	logic                   s_awvalid;
	logic                   s_awready;
	logic [31:0]            s_wdata;
	logic [3:0]             s_wstrb;
	logic                   s_wvalid;
	logic                   s_wready;
	logic [1:0]             s_bresp;
	logic                   s_bvalid;
	logic                   s_bready;
	logic [4:0]             s_araddr;
	logic                   s_arvalid;
	logic                   s_arready;
	logic [31:0]            s_rdata;
	logic [1:0]             s_rresp;
	logic                   s_rvalid;
	logic                   s_rready;
	logic                   pixel_valid;
	logic [coord_bits-1:0]  pixel_x;
	logic [coord_bits-1:0]  pixel_y;
	logic                   pixel_ready;
	logic                   end_of_test;
	logic                   reported;
	int                     chk_errors;
	int                     pixels_seen;
	int                     reads_seen;
	int                     tb_errors;

	bla_top #(.COORD_BITS(coord_bits)) dut0 (
		.clk(clk), .reset(reset),
		.s_awaddr(s_awaddr), .s_awvalid(s_awvalid), .s_awready(s_awready),
		.s_wdata(s_wdata), .s_wstrb(s_wstrb), .s_wvalid(s_wvalid), .s_wready(s_wready),
		.s_bresp(s_bresp), .s_bvalid(s_bvalid), .s_bready(s_bready),
		.s_araddr(s_araddr), .s_arvalid(s_arvalid), .s_arready(s_arready),
		.s_rdata(s_rdata), .s_rresp(s_rresp), .s_rvalid(s_rvalid), .s_rready(s_rready),
		.pixel_valid(pixel_valid), .pixel_x(pixel_x), .pixel_y(pixel_y),
		.pixel_ready(pixel_ready)
	);

	bla_checker #(.COORD_BITS(coord_bits)) chk0 (
		.clk(clk), .reset(reset),
		.awaddr(s_awaddr), .awvalid(s_awvalid), .awready(s_awready),
		.wdata(s_wdata), .wstrb(s_wstrb), .wvalid(s_wvalid), .wready(s_wready),
		.bresp(s_bresp), .bvalid(s_bvalid), .bready(s_bready),
		.araddr(s_araddr), .arvalid(s_arvalid), .arready(s_arready),
		.rdata(s_rdata), .rresp(s_rresp), .rvalid(s_rvalid), .rready(s_rready),
		.pixel_valid(pixel_valid), .pixel_ready(pixel_ready),
		.pixel_x(pixel_x), .pixel_y(pixel_y),
		.end_of_test(end_of_test), .reported(reported),
		.error_count(chk_errors), .pixel_count(pixels_seen), .read_count(reads_seen)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Sink stalls with ready about 70 percent of cycles
	initial
	begin
		pixel_ready = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			pixel_ready = (($urandom % 100) < 70);
		end
	end

	task automatic report_timeout(input string what);
		$display("Timeout waiting for %s", what);
		tb_errors++;
	endtask

	task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int n;
		s_awaddr  = addr;
		s_wdata   = data;
		s_wstrb   = strb;
		s_awvalid = 1'b1;
		s_wvalid  = 1'b1;
		n = 0;
		while (!(s_awready && s_wready) && n < timeout_cycles)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (n >= timeout_cycles)
			report_timeout("write address ready");
		@(posedge clk);
		#1;
		s_awvalid = 1'b0;
		s_wvalid  = 1'b0;
		n = 0;
		while (!s_bvalid && n < timeout_cycles)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (n >= timeout_cycles)
			report_timeout("write response");
		@(posedge clk);
		#1;
	endtask

	task automatic axi_read(input logic [4:0] addr, output logic [31:0] data);
		int n;
		s_araddr  = addr;
		s_arvalid = 1'b1;
		n = 0;
		while (!s_arready && n < timeout_cycles)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (n >= timeout_cycles)
			report_timeout("read address ready");
		@(posedge clk);
		#1;
		s_arvalid = 1'b0;
		n = 0;
		while (!s_rvalid && n < timeout_cycles)
		begin
			@(posedge clk);
			#1;
			n++;
		end
		if (n >= timeout_cycles)
			report_timeout("read data");
		data = s_rdata;
		@(posedge clk);
		#1;
	endtask

	task automatic program_vertex(input int idx, input logic [7:0] x, input logic [7:0] y);
		axi_write(reg_vert0 + 5'(4 * idx), {16'd0, y, x}, 4'hf);
	endtask

	// Poll for done, then clear it and read it back
	task automatic wait_done();
		logic [31:0] status;
		int polls;
		polls = 0;
		status = '0;
		while (!status[1] && polls < poll_limit)
		begin
			axi_read(reg_status, status);
			polls++;
		end
		if (!status[1])
			report_timeout("status done");
		axi_write(reg_status, 32'h2, 4'h1);
		axi_read(reg_status, status);
	endtask

	task automatic draw_shape(input logic tri_shape);
		axi_write(reg_ctrl, {30'd0, tri_shape, 1'b1}, 4'h1);
		wait_done();
	endtask

	task automatic check_registers();
		logic [31:0] data;
		for (int i = 0; i < 3; i++)
		begin
			axi_write(reg_vert0 + 5'(4 * i), $urandom, 4'hf);
			axi_read(reg_vert0 + 5'(4 * i), data);
			axi_write(reg_vert0 + 5'(4 * i), $urandom, 4'($urandom));
			axi_read(reg_vert0 + 5'(4 * i), data);
		end
		axi_write(reg_ctrl, 32'h2, 4'h1);
		axi_read(reg_ctrl, data);
		axi_write(reg_ctrl, 32'h0, 4'h1);
		axi_read(reg_ctrl, data);
		axi_read(5'h14, data);
		axi_read(5'h18, data);
		axi_read(5'h1C, data);
		axi_read(reg_status, data);
	endtask

	// Bits 0 and 1 pick the x and y direction and bit 2 a steep line
	task automatic draw_random_line(input int octant);
		logic [7:0] xa;
		logic [7:0] ya;
		logic [7:0] xb;
		logic [7:0] yb;
		logic [7:0] t;
		int ax;
		int ay;
		xa = 8'($urandom);
		ya = 8'($urandom);
		xb = 8'($urandom);
		yb = 8'($urandom);
		ax = int'(xb) - int'(xa);
		ay = int'(yb) - int'(ya);
		if (ax < 0)
			ax = -ax;
		if (ay < 0)
			ay = -ay;
		if ((ay > ax) != octant[2])
		begin
			t = xa;
			xa = ya;
			ya = t;
			t = xb;
			xb = yb;
			yb = t;
		end
		if ((xb < xa) != octant[0])
		begin
			t = xa;
			xa = xb;
			xb = t;
		end
		if ((yb < ya) != octant[1])
		begin
			t = ya;
			ya = yb;
			yb = t;
		end
		program_vertex(0, xa, ya);
		program_vertex(1, xb, yb);
		draw_shape(1'b0);
	endtask

	initial
	begin
		void'($urandom(32'h3f63870f));
		tb_errors   = 0;
		end_of_test = 1'b0;
		s_awaddr    = '0;
		s_awvalid   = 1'b0;
		s_wdata     = '0;
		s_wstrb     = '0;
		s_wvalid    = 1'b0;
		s_bready    = 1'b1;
		s_araddr    = '0;
		s_arvalid   = 1'b0;
		s_rready    = 1'b1;
		reset       = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		check_registers();
		for (int i = 0; i < 40; i++)
			draw_random_line(i);

		// A second start while the line is still drawing
		program_vertex(0, 8'd0, 8'd0);
		program_vertex(1, 8'd255, 8'd100);
		axi_write(reg_ctrl, 32'h1, 4'h1);
		axi_write(reg_ctrl, 32'h3, 4'h1);
		wait_done();

		for (int i = 0; i < 6; i++)
		begin
			program_vertex(0, 8'($urandom), 8'($urandom));
			program_vertex(1, 8'($urandom), 8'($urandom));
			program_vertex(2, 8'($urandom), 8'($urandom));
			draw_shape(1'b1);
		end

		program_vertex(0, 8'd77, 8'd33);
		program_vertex(1, 8'd77, 8'd33);
		draw_shape(1'b0);

		end_of_test = 1'b1;
		for (int n = 0; n < timeout_cycles && !reported; n++)
		begin
			@(posedge clk);
			#1;
		end
		if (!reported)
			report_timeout("checker report");
		$display("Summary: %0d pixels and %0d reads checked, %0d errors, %0d timeouts",
			pixels_seen, reads_seen, chk_errors, tb_errors);
		if (chk_errors == 0 && tb_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
